//--- Bender.yml
package:
  name: priv_block

sources:
  - logic/rv32i_types_pkg.sv
  - logic/machine_mode_types_pkg.sv
  - logic/csr_rfile.sv
  - logic/trap_control.sv
  - logic/priv_block.sv
  - target: test
    files:
      - verification/priv_block_sva.sv
      - verification/priv_block_tb.sv

//--- build.f
logic/rv32i_types_pkg.sv
logic/machine_mode_types_pkg.sv
logic/csr_rfile.sv
logic/trap_control.sv
logic/priv_block.sv
verification/priv_block_sva.sv
verification/priv_block_tb.sv

//--- logic/csr_rfile.sv
// Machine-mode CSR storage, serving pipeline read-modify-write accesses and trap updates
`timescale 1ns/1ps
`default_nettype none

module csr_rfile (
  input  wire logic                                CLK,
  input  wire logic                                nRST,
  input  wire rv32i_types_pkg::csr_req_t           csr_req,
  input  wire machine_mode_types_pkg::csr_update_t update,
  output rv32i_types_pkg::word_t                   csr_rdata,
  output logic                                     invalid_csr,
  output machine_mode_types_pkg::csr_view_t        view
);

  // Stored state, everything else is tied off
  logic                               mstatus_ie;
  logic                               mie_meie;
  machine_mode_types_pkg::mscratch_t  mscratch;
  machine_mode_types_pkg::mepc_t      mepc;
  machine_mode_types_pkg::mcause_t    mcause;
  machine_mode_types_pkg::mbadaddr_t  mbadaddr;
  machine_mode_types_pkg::mtohost_t   mtohost;
  machine_mode_types_pkg::mfromhost_t mfromhost;

  // Full register images for reads
  machine_mode_types_pkg::mstatus_t mstatus;
  machine_mode_types_pkg::mie_t     mie;
  machine_mode_types_pkg::mip_t     mip;
  machine_mode_types_pkg::mcpuid_t  mcpuid;
  machine_mode_types_pkg::mtvec_t   mtvec;

  // Pipeline access decode
  logic                             csr_op;
  logic                             valid_addr;
  rv32i_types_pkg::word_t           rup_data;
  machine_mode_types_pkg::mstatus_t rup_mstatus;
  machine_mode_types_pkg::mie_t     rup_mie;
  logic                             wr_mstatus;
  logic                             wr_mie;
  logic                             wr_mscratch;
  logic                             wr_mtohost;
  logic                             wr_mfromhost;

  // Machine mode only, no VM, no FPU
  always_comb begin
    mstatus      = '0;
    mstatus.vm   = machine_mode_types_pkg::VM_MBARE;
    mstatus.xs   = machine_mode_types_pkg::XS_ALL_OFF;
    mstatus.fs   = machine_mode_types_pkg::FS_OFF;
    mstatus.prv3 = machine_mode_types_pkg::M_MODE;
    mstatus.prv2 = machine_mode_types_pkg::M_MODE;
    mstatus.prv1 = machine_mode_types_pkg::M_MODE;
    mstatus.prv  = machine_mode_types_pkg::M_MODE;
    mstatus.ie   = mstatus_ie;
  end

  // Only the external interrupt enable exists
  always_comb begin
    mie      = '0;
    mie.meie = mie_meie;
  end

  // No timer or software interrupts pending
  assign mip = '0;

  assign mcpuid.base       = machine_mode_types_pkg::BASE_RV32;
  assign mcpuid.zero       = '0;
  assign mcpuid.extensions = machine_mode_types_pkg::MCPUID_EXT_I;

  assign mtvec = machine_mode_types_pkg::MTVEC_ADDR;

  // Read mux, also flags addresses outside the map
  always_comb begin
    valid_addr = 1'b1;
    csr_rdata  = '0;
    case (csr_req.addr)
      machine_mode_types_pkg::CSR_MCPUID:    csr_rdata = mcpuid;
      // Implementation id and hart 0
      machine_mode_types_pkg::CSR_MIMPID,
      machine_mode_types_pkg::CSR_MHARTID:   csr_rdata = '0;
      machine_mode_types_pkg::CSR_MSTATUS:   csr_rdata = mstatus;
      machine_mode_types_pkg::CSR_MTVEC:     csr_rdata = mtvec;
      // No delegation
      machine_mode_types_pkg::CSR_MTDELEG:   csr_rdata = '0;
      machine_mode_types_pkg::CSR_MIE:       csr_rdata = mie;
      machine_mode_types_pkg::CSR_MSCRATCH:  csr_rdata = mscratch;
      machine_mode_types_pkg::CSR_MEPC:      csr_rdata = mepc;
      machine_mode_types_pkg::CSR_MCAUSE:    csr_rdata = mcause;
      machine_mode_types_pkg::CSR_MBADADDR:  csr_rdata = mbadaddr;
      machine_mode_types_pkg::CSR_MIP:       csr_rdata = mip;
      // Protection, timers and deltas are absent but legal
      machine_mode_types_pkg::CSR_MBASE,
      machine_mode_types_pkg::CSR_MBOUND,
      machine_mode_types_pkg::CSR_MIBASE,
      machine_mode_types_pkg::CSR_MIBOUND,
      machine_mode_types_pkg::CSR_MDBASE,
      machine_mode_types_pkg::CSR_MDBOUND,
      machine_mode_types_pkg::CSR_MTIMECMP,
      machine_mode_types_pkg::CSR_MTIME,
      machine_mode_types_pkg::CSR_MTIMEH,
      machine_mode_types_pkg::CSR_MTIME_DELTA,
      machine_mode_types_pkg::CSR_MTIMEH_DELTA: csr_rdata = '0;
      // Host interface for test programs
      machine_mode_types_pkg::CSR_MTOHOST:   csr_rdata = mtohost;
      machine_mode_types_pkg::CSR_MFROMHOST: csr_rdata = mfromhost;
      default:                               valid_addr = 1'b0;
    endcase
  end

  assign csr_op      = csr_req.swap | csr_req.set | csr_req.clr;
  assign invalid_csr = csr_op & ~valid_addr;

  // Merge operand into old value, set is the fall-through
  assign rup_data = csr_req.swap ? csr_req.wdata :
                    csr_req.clr  ? (csr_rdata & ~csr_req.wdata) :
                                   (csr_rdata | csr_req.wdata);

  assign rup_mstatus = machine_mode_types_pkg::mstatus_t'(rup_data);
  assign rup_mie     = machine_mode_types_pkg::mie_t'(rup_data);

  // Pipeline-writable registers
  assign wr_mstatus   = csr_op & (csr_req.addr == machine_mode_types_pkg::CSR_MSTATUS);
  assign wr_mie       = csr_op & (csr_req.addr == machine_mode_types_pkg::CSR_MIE);
  assign wr_mscratch  = csr_op & (csr_req.addr == machine_mode_types_pkg::CSR_MSCRATCH);
  assign wr_mtohost   = csr_op & (csr_req.addr == machine_mode_types_pkg::CSR_MTOHOST);
  assign wr_mfromhost = csr_op & (csr_req.addr == machine_mode_types_pkg::CSR_MFROMHOST);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      // Interrupts enabled out of reset
      mstatus_ie <= 1'b1;
      mie_meie   <= 1'b1;
      mscratch   <= '0;
      mepc       <= '0;
      mcause     <= '0;
      mbadaddr   <= '0;
      mtohost    <= '0;
      mfromhost  <= '0;
    end else begin
      // Pipeline write wins over trap or MRET
      if (wr_mstatus) begin
        mstatus_ie <= rup_mstatus.ie;
      end else if (update.mstatus_rup) begin
        mstatus_ie <= update.mstatus_next.ie;
      end
      if (wr_mie) begin
        mie_meie <= rup_mie.meie;
      end
      if (wr_mscratch) begin
        mscratch <= rup_data;
      end
      if (wr_mtohost) begin
        mtohost <= rup_data;
      end
      if (wr_mfromhost) begin
        mfromhost <= rup_data;
      end
      // Trap-only registers, read-only to the pipeline
      if (update.mepc_rup) begin
        mepc <= update.mepc_next;
      end
      if (update.mcause_rup) begin
        mcause <= update.mcause_next;
      end
      if (update.mbadaddr_rup) begin
        mbadaddr <= update.mbadaddr_next;
      end
    end
  end

  assign view.mstatus = mstatus;
  assign view.mie     = mie;
  assign view.mepc    = mepc;
  assign view.mtvec   = mtvec;

endmodule

`default_nettype wire

//--- logic/machine_mode_types_pkg.sv
// Machine-mode CSR layouts, CSR map, cause codes and trap vector for the privilege block
`default_nettype none

package machine_mode_types_pkg;

  // Privilege levels
  typedef enum logic [1:0] {
    U_MODE = 2'd0,
    S_MODE = 2'd1,
    H_MODE = 2'd2,
    M_MODE = 2'd3
  } prv_t;

  // Virtualization modes, only bare is supported
  typedef enum logic [4:0] {
    VM_MBARE  = 5'd0,
    VM_MBB    = 5'd1,
    VM_MBBID  = 5'd2,
    VM_SV32   = 5'd8
  } vm_t;

  // Extension and FPU context status
  typedef enum logic [1:0] {
    XS_ALL_OFF, XS_NONE_DIRTY_CLEAN, XS_SOME_CLEAN, XS_SOME_DIRTY
  } xs_t;

  typedef enum logic [1:0] {
    FS_OFF, FS_INITIAL, FS_CLEAN, FS_DIRTY
  } fs_t;

  // mstatus in 1.7 layout, MSB first
  typedef struct packed {
    logic       sd;
    logic [8:0] zero;
    vm_t        vm;
    logic       mprv;
    xs_t        xs;
    fs_t        fs;
    // Privilege and interrupt-enable stack
    prv_t       prv3;
    logic       ie3;
    prv_t       prv2;
    logic       ie2;
    prv_t       prv1;
    logic       ie1;
    prv_t       prv;
    logic       ie;
  } mstatus_t;

  // Interrupt enable, only meie is live
  typedef struct packed {
    logic [19:0] zero_3;
    logic        meie;
    logic [2:0]  zero_2;
    logic        mtie;
    logic        htie;
    logic        stie;
    logic        zero_1;
    logic        msie;
    logic        hsie;
    logic        ssie;
    logic        zero_0;
  } mie_t;

  // Interrupt pending, same bit positions as mie
  typedef struct packed {
    logic [19:0] zero_3;
    logic        meip;
    logic [2:0]  zero_2;
    logic        mtip;
    logic        htip;
    logic        stip;
    logic        zero_1;
    logic        msip;
    logic        hsip;
    logic        ssip;
    logic        zero_0;
  } mip_t;

  // CPU base ISA and extension bits
  typedef struct packed {
    logic [1:0]  base;
    logic [3:0]  zero;
    logic [25:0] extensions;
  } mcpuid_t;

  localparam logic [1:0]  BASE_RV32    = 2'b00;
  // Bit 8 is the letter I
  localparam logic [25:0] MCPUID_EXT_I = 26'h000_0100;

  // Top bit flags an interrupt
  typedef struct packed {
    logic        intr;
    logic [30:0] code;
  } mcause_t;

  // Plain word registers
  typedef rv32i_types_pkg::word_t mepc_t;
  typedef rv32i_types_pkg::word_t mscratch_t;
  typedef rv32i_types_pkg::word_t mbadaddr_t;
  typedef rv32i_types_pkg::word_t mtvec_t;
  typedef rv32i_types_pkg::word_t mtohost_t;
  typedef rv32i_types_pkg::word_t mfromhost_t;

  // CSR map
  localparam rv32i_types_pkg::csr_addr_t CSR_MCPUID      = 12'hF00;
  localparam rv32i_types_pkg::csr_addr_t CSR_MIMPID      = 12'hF01;
  localparam rv32i_types_pkg::csr_addr_t CSR_MHARTID     = 12'hF10;
  localparam rv32i_types_pkg::csr_addr_t CSR_MSTATUS     = 12'h300;
  localparam rv32i_types_pkg::csr_addr_t CSR_MTVEC       = 12'h301;
  localparam rv32i_types_pkg::csr_addr_t CSR_MTDELEG     = 12'h302;
  localparam rv32i_types_pkg::csr_addr_t CSR_MIE         = 12'h304;
  localparam rv32i_types_pkg::csr_addr_t CSR_MTIMECMP    = 12'h321;
  localparam rv32i_types_pkg::csr_addr_t CSR_MSCRATCH    = 12'h340;
  localparam rv32i_types_pkg::csr_addr_t CSR_MEPC        = 12'h341;
  localparam rv32i_types_pkg::csr_addr_t CSR_MCAUSE      = 12'h342;
  localparam rv32i_types_pkg::csr_addr_t CSR_MBADADDR    = 12'h343;
  localparam rv32i_types_pkg::csr_addr_t CSR_MIP         = 12'h344;
  localparam rv32i_types_pkg::csr_addr_t CSR_MBASE       = 12'h380;
  localparam rv32i_types_pkg::csr_addr_t CSR_MBOUND      = 12'h381;
  localparam rv32i_types_pkg::csr_addr_t CSR_MIBASE      = 12'h382;
  localparam rv32i_types_pkg::csr_addr_t CSR_MIBOUND     = 12'h383;
  localparam rv32i_types_pkg::csr_addr_t CSR_MDBASE      = 12'h384;
  localparam rv32i_types_pkg::csr_addr_t CSR_MDBOUND     = 12'h385;
  localparam rv32i_types_pkg::csr_addr_t CSR_MTIME       = 12'h701;
  localparam rv32i_types_pkg::csr_addr_t CSR_MTIMEH      = 12'h741;
  localparam rv32i_types_pkg::csr_addr_t CSR_MTIME_DELTA  = 12'hB01;
  localparam rv32i_types_pkg::csr_addr_t CSR_MTIMEH_DELTA = 12'hB81;
  localparam rv32i_types_pkg::csr_addr_t CSR_MTOHOST     = 12'h780;
  localparam rv32i_types_pkg::csr_addr_t CSR_MFROMHOST   = 12'h781;

  // Fixed trap entry point
  localparam rv32i_types_pkg::word_t MTVEC_ADDR = 32'h0000_0100;

  // Cause codes
  localparam rv32i_types_pkg::word_t CAUSE_FETCH_MISALIGNED = 32'd0;
  localparam rv32i_types_pkg::word_t CAUSE_ILLEGAL          = 32'd2;
  localparam rv32i_types_pkg::word_t CAUSE_BREAKPOINT       = 32'd3;
  localparam rv32i_types_pkg::word_t CAUSE_ECALL_M          = 32'd11;
  localparam rv32i_types_pkg::word_t CAUSE_EXT_INT          = 32'h8000_000B;

  // Trap controller to register file
  typedef struct packed {
    logic      mepc_rup;
    mepc_t     mepc_next;
    logic      mcause_rup;
    mcause_t   mcause_next;
    logic      mbadaddr_rup;
    mbadaddr_t mbadaddr_next;
    logic      mstatus_rup;
    mstatus_t  mstatus_next;
  } csr_update_t;

  // Register file to trap controller
  typedef struct packed {
    mstatus_t mstatus;
    mie_t     mie;
    mepc_t    mepc;
    mtvec_t   mtvec;
  } csr_view_t;

endpackage

`default_nettype wire

//--- logic/priv_block.sv
// Machine-mode privilege block top, joining the CSR register file and the trap controller
`timescale 1ns/1ps
`default_nettype none

module priv_block (
  input  wire logic                      CLK,
  input  wire logic                      nRST,
  input  wire rv32i_types_pkg::csr_req_t csr_req,
  input  wire rv32i_types_pkg::exc_req_t exc,
  input  wire logic                      ext_int,
  input  wire logic                      mret,
  output rv32i_types_pkg::word_t         csr_rdata,
  output logic                           invalid_csr,
  output logic                           insert_pc,
  output rv32i_types_pkg::word_t         priv_pc
);

  // Current CSR state toward the trap logic
  machine_mode_types_pkg::csr_view_t   view;
  // Trap and MRET writes back into the register file
  machine_mode_types_pkg::csr_update_t update;

  csr_rfile rfile_i (
    .CLK         (CLK),
    .nRST        (nRST),
    .csr_req     (csr_req),
    .update      (update),
    .csr_rdata   (csr_rdata),
    .invalid_csr (invalid_csr),
    .view        (view)
  );

  // invalid_csr feeds back as an illegal-instruction source
  trap_control trap_i (
    .exc         (exc),
    .invalid_csr (invalid_csr),
    .ext_int     (ext_int),
    .mret        (mret),
    .view        (view),
    .update      (update),
    .insert_pc   (insert_pc),
    .priv_pc     (priv_pc)
  );

endmodule

`default_nettype wire

//--- logic/rv32i_types_pkg.sv
// Base RV32I word, CSR address and pipeline request types shared by the privilege block
`default_nettype none

package rv32i_types_pkg;

  // Data word and CSR address widths
  typedef logic [31:0] word_t;
  typedef logic [11:0] csr_addr_t;

  // CSR instruction as seen by the privilege block
  // At most one of swap, set and clr is high
  typedef struct packed {
    csr_addr_t addr;
    // CSRRW
    logic      swap;
    // CSRRS
    logic      set;
    // CSRRC
    logic      clr;
    // Register or immediate operand
    word_t     wdata;
  } csr_req_t;

  // Exception flags of the instruction in the trap stage
  typedef struct packed {
    logic  fetch_misaligned;
    logic  illegal;
    logic  breakpoint;
    logic  ecall;
    // PC of the faulting instruction
    word_t epc;
    // Target address, only meaningful on a misaligned fetch
    word_t badaddr;
  } exc_req_t;

endpackage

`default_nettype wire

//--- logic/trap_control.sv
// Combinational trap and MRET decision logic driving CSR updates and the redirect PC
`timescale 1ns/1ps
`default_nettype none

module trap_control (
  input  wire rv32i_types_pkg::exc_req_t          exc,
  input  wire logic                               invalid_csr,
  input  wire logic                               ext_int,
  input  wire logic                               mret,
  input  wire machine_mode_types_pkg::csr_view_t  view,
  output machine_mode_types_pkg::csr_update_t     update,
  output logic                                    insert_pc,
  output rv32i_types_pkg::word_t                  priv_pc
);

  logic                   illegal_any;
  logic                   exc_any;
  logic                   int_taken;
  logic                   trap;
  logic                   mret_taken;
  rv32i_types_pkg::word_t exc_cause;
  rv32i_types_pkg::word_t cause;

  // Bad CSR address counts as an illegal instruction
  assign illegal_any = exc.illegal | invalid_csr;

  assign exc_any = exc.fetch_misaligned | illegal_any | exc.breakpoint | exc.ecall;

  // Exception priority, fetch first
  always_comb begin
    if (exc.fetch_misaligned) begin
      exc_cause = machine_mode_types_pkg::CAUSE_FETCH_MISALIGNED;
    end else if (illegal_any) begin
      exc_cause = machine_mode_types_pkg::CAUSE_ILLEGAL;
    end else if (exc.breakpoint) begin
      exc_cause = machine_mode_types_pkg::CAUSE_BREAKPOINT;
    end else begin
      exc_cause = machine_mode_types_pkg::CAUSE_ECALL_M;
    end
  end

  // Global and per-source enable
  assign int_taken = ext_int & view.mstatus.ie & view.mie.meie;

  // Exceptions beat the interrupt
  assign trap  = exc_any | int_taken;
  assign cause = exc_any ? exc_cause : machine_mode_types_pkg::CAUSE_EXT_INT;

  // Trap overrides MRET
  assign mret_taken = mret & ~trap;

  always_comb begin
    update               = '0;
    update.mepc_rup      = trap;
    update.mepc_next     = exc.epc;
    update.mcause_rup    = trap;
    update.mcause_next   = machine_mode_types_pkg::mcause_t'(cause);
    // Misaligned fetch is top priority so its flag alone selects the cause
    update.mbadaddr_rup  = exc.fetch_misaligned;
    update.mbadaddr_next = exc.badaddr;
    // Trap clears ie, MRET sets it again
    update.mstatus_rup     = trap | mret_taken;
    update.mstatus_next    = view.mstatus;
    update.mstatus_next.ie = mret_taken;
  end

  // Redirect to the vector or back to the saved PC
  assign insert_pc = trap | mret_taken;
  assign priv_pc   = trap ? view.mtvec : view.mepc;

endmodule

`default_nettype wire

//--- verification/priv_block_sva.sv
// Concurrent checks on the privilege block ports, bound into the top level
`timescale 1ns/1ps
`default_nettype none

module priv_block_sva (
  input wire logic                      CLK,
  input wire logic                      nRST,
  input wire rv32i_types_pkg::csr_req_t csr_req,
  input wire logic                      mret,
  input wire rv32i_types_pkg::word_t    csr_rdata,
  input wire logic                      invalid_csr,
  input wire logic                      insert_pc,
  input wire rv32i_types_pkg::word_t    priv_pc
);

  // Failures seen so far, summed by the testbench
  int assert_fail_cnt = 0;

  // Bad address reads back as zero
  invalid_rdata_zero: assert property (@(posedge CLK) disable iff (!nRST)
    invalid_csr |-> csr_rdata == '0)
  else begin
    assert_fail_cnt++;
    $error("Invalid CSR access returned nonzero read data");
  end

  // No redirect while reset is held
  no_redirect_in_reset: assert property (@(posedge CLK) !nRST |-> !insert_pc)
  else begin
    assert_fail_cnt++;
    $error("Redirect raised during reset");
  end

  // Redirect without MRET is a trap and goes to the vector
  trap_to_vector: assert property (@(posedge CLK) disable iff (!nRST)
    (insert_pc && !mret) |-> priv_pc == machine_mode_types_pkg::MTVEC_ADDR)
  else begin
    assert_fail_cnt++;
    $error("Trap redirect does not target the trap vector");
  end

  // At most one access strobe
  strobes_onehot: assert property (@(posedge CLK) disable iff (!nRST)
    $onehot0({csr_req.swap, csr_req.set, csr_req.clr}))
  else begin
    assert_fail_cnt++;
    $error("More than one CSR access strobe high");
  end

endmodule

bind priv_block priv_block_sva sva_i (
  .CLK         (CLK),
  .nRST        (nRST),
  .csr_req     (csr_req),
  .mret        (mret),
  .csr_rdata   (csr_rdata),
  .invalid_csr (invalid_csr),
  .insert_pc   (insert_pc),
  .priv_pc     (priv_pc)
);

`default_nettype wire

//--- verification/priv_block_tb.sv
// Testbench for the machine-mode privilege block, with directed and random stimulus and a CSR model
`timescale 1ns/1ps
`default_nettype none

module priv_block_tb;

  // Cycle budget per test summed for the watchdog
  localparam int RESET_CYCLES   = 5;
  localparam int MAP_SIZE       = 25;
  localparam int RMW_ROUNDS     = 20;
  localparam int PRIO_ROUNDS    = 16;
  localparam int BUDGET         = RESET_CYCLES + MAP_SIZE + RMW_ROUNDS * 2 + 6 + 4
                                  + PRIO_ROUNDS * 5 + 16 + 50;
  // mstatus with every priv field at M_MODE and ie clear
  localparam rv32i_types_pkg::word_t MSTATUS_FIXED = 32'h0000_0DB6;

  logic                      CLK;
  logic                      nRST;
  rv32i_types_pkg::csr_req_t csr_req;
  rv32i_types_pkg::exc_req_t exc;
  logic                      ext_int;
  logic                      mret;
  rv32i_types_pkg::word_t    csr_rdata;
  logic                      invalid_csr;
  logic                      insert_pc;
  rv32i_types_pkg::word_t    priv_pc;

  // Reference model of the stored CSR state
  logic                   m_ie;
  logic                   m_meie;
  rv32i_types_pkg::word_t m_mscratch;
  rv32i_types_pkg::word_t m_mepc;
  rv32i_types_pkg::word_t m_mcause;
  rv32i_types_pkg::word_t m_mbadaddr;
  rv32i_types_pkg::word_t m_mtohost;
  rv32i_types_pkg::word_t m_mfromhost;

  int seed = 18186;
  int pass_cnt = 0;
  int fail_cnt = 0;
  int fails_before;
  int sel;
  rv32i_types_pkg::csr_addr_t map_addrs [0:MAP_SIZE-1] = '{
    machine_mode_types_pkg::CSR_MCPUID, machine_mode_types_pkg::CSR_MIMPID,
    machine_mode_types_pkg::CSR_MHARTID, machine_mode_types_pkg::CSR_MSTATUS,
    machine_mode_types_pkg::CSR_MTVEC, machine_mode_types_pkg::CSR_MTDELEG,
    machine_mode_types_pkg::CSR_MIE, machine_mode_types_pkg::CSR_MTIMECMP,
    machine_mode_types_pkg::CSR_MSCRATCH, machine_mode_types_pkg::CSR_MEPC,
    machine_mode_types_pkg::CSR_MCAUSE, machine_mode_types_pkg::CSR_MBADADDR,
    machine_mode_types_pkg::CSR_MIP, machine_mode_types_pkg::CSR_MBASE,
    machine_mode_types_pkg::CSR_MBOUND, machine_mode_types_pkg::CSR_MIBASE,
    machine_mode_types_pkg::CSR_MIBOUND, machine_mode_types_pkg::CSR_MDBASE,
    machine_mode_types_pkg::CSR_MDBOUND, machine_mode_types_pkg::CSR_MTIME,
    machine_mode_types_pkg::CSR_MTIMEH, machine_mode_types_pkg::CSR_MTIME_DELTA,
    machine_mode_types_pkg::CSR_MTIMEH_DELTA, machine_mode_types_pkg::CSR_MTOHOST,
    machine_mode_types_pkg::CSR_MFROMHOST
  };

  priv_block dut_i (
    .CLK         (CLK),
    .nRST        (nRST),
    .csr_req     (csr_req),
    .exc         (exc),
    .ext_int     (ext_int),
    .mret        (mret),
    .csr_rdata   (csr_rdata),
    .invalid_csr (invalid_csr),
    .insert_pc   (insert_pc),
    .priv_pc     (priv_pc)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  // Expected read value from the CSR map and field layouts
  function automatic rv32i_types_pkg::word_t model_read(input rv32i_types_pkg::csr_addr_t a);
    case (a)
      machine_mode_types_pkg::CSR_MCPUID:    return 32'h0000_0100;
      machine_mode_types_pkg::CSR_MSTATUS:   return MSTATUS_FIXED | {31'b0, m_ie};
      machine_mode_types_pkg::CSR_MTVEC:     return machine_mode_types_pkg::MTVEC_ADDR;
      machine_mode_types_pkg::CSR_MIE:       return {20'b0, m_meie, 11'b0};
      machine_mode_types_pkg::CSR_MSCRATCH:  return m_mscratch;
      machine_mode_types_pkg::CSR_MEPC:      return m_mepc;
      machine_mode_types_pkg::CSR_MCAUSE:    return m_mcause;
      machine_mode_types_pkg::CSR_MBADADDR:  return m_mbadaddr;
      machine_mode_types_pkg::CSR_MTOHOST:   return m_mtohost;
      machine_mode_types_pkg::CSR_MFROMHOST: return m_mfromhost;
      default:                               return '0;
    endcase
  endfunction

  // Only these fields take pipeline writes
  task automatic model_write(input rv32i_types_pkg::csr_addr_t a,
                             input rv32i_types_pkg::word_t d);
    case (a)
      machine_mode_types_pkg::CSR_MSTATUS:   m_ie = d[0];
      machine_mode_types_pkg::CSR_MIE:       m_meie = d[11];
      machine_mode_types_pkg::CSR_MSCRATCH:  m_mscratch = d;
      machine_mode_types_pkg::CSR_MTOHOST:   m_mtohost = d;
      machine_mode_types_pkg::CSR_MFROMHOST: m_mfromhost = d;
      default: ;
    endcase
  endtask

  task automatic check_value(input string name, input rv32i_types_pkg::word_t actual,
                             input rv32i_types_pkg::word_t expected);
    assert (actual === expected) pass_cnt++;
    else begin
      fail_cnt++;
      $display("FAIL %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic clear_inputs();
    csr_req = '0;
    exc     = '0;
    ext_int = 1'b0;
    mret    = 1'b0;
  endtask

  // Next drive point 1 ns after the rising edge
  task automatic next_drive();
    @(posedge CLK);
    #1;
    clear_inputs();
  endtask

  // Op 0 swap, 1 set, 2 clear
  // Old value comes back in the same cycle
  task automatic rmw_check(input rv32i_types_pkg::csr_addr_t a, input int op,
                           input rv32i_types_pkg::word_t w);
    rv32i_types_pkg::word_t old;
    old = model_read(a);
    next_drive();
    csr_req.addr  = a;
    csr_req.swap  = (op == 0);
    csr_req.set   = (op == 1);
    csr_req.clr   = (op == 2);
    csr_req.wdata = w;
    #1;
    check_value("csr_rdata", csr_rdata, old);
    check_value("invalid_csr", invalid_csr, 0);
    check_value("insert_pc", insert_pc, 0);
    model_write(a, (op == 0) ? w : (op == 1) ? (old | w) : (old & ~w));
  endtask

  // Trap, MRET or nothing depending on flags and enables
  task automatic event_check(input logic [3:0] flags, input logic ext, input logic do_mret);
    rv32i_types_pkg::word_t epc;
    rv32i_types_pkg::word_t bad;
    logic                   trap;
    epc = $random(seed) & ~32'h3;
    bad = $random(seed);
    trap = (flags != 4'b0) || (ext && m_ie && m_meie);
    next_drive();
    {exc.fetch_misaligned, exc.illegal, exc.breakpoint, exc.ecall} = flags;
    exc.epc     = epc;
    exc.badaddr = bad;
    ext_int     = ext;
    mret        = do_mret;
    #1;
    check_value("insert_pc", insert_pc, trap || do_mret);
    if (trap) begin
      check_value("priv_pc", priv_pc, machine_mode_types_pkg::MTVEC_ADDR);
      m_mepc   = epc;
      m_ie     = 1'b0;
      m_mcause = flags[3] ? machine_mode_types_pkg::CAUSE_FETCH_MISALIGNED :
                 flags[2] ? machine_mode_types_pkg::CAUSE_ILLEGAL :
                 flags[1] ? machine_mode_types_pkg::CAUSE_BREAKPOINT :
                 flags[0] ? machine_mode_types_pkg::CAUSE_ECALL_M :
                            machine_mode_types_pkg::CAUSE_EXT_INT;
      if (flags[3]) begin
        m_mbadaddr = bad;
      end
    end else if (do_mret) begin
      check_value("priv_pc", priv_pc, m_mepc);
      m_ie = 1'b1;
    end
  endtask

  task automatic report_test(input string name);
    $display("test %s finished with %0d errors", name, fail_cnt - fails_before);
    fails_before = fail_cnt;
  endtask

  initial begin
    repeat (BUDGET) @(posedge CLK);
    $display("Timeout: tests did not finish within %0d cycles", BUDGET);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    clear_inputs();
    nRST = 1'b0;
    {m_ie, m_meie} = 2'b11;
    {m_mscratch, m_mepc, m_mcause, m_mbadaddr, m_mtohost, m_mfromhost} = '0;
    fails_before = 0;
    repeat (RESET_CYCLES) @(posedge CLK);
    #1 nRST = 1'b1;

    // Whole map reads its reset values
    for (int i = 0; i < MAP_SIZE; i++) begin
      rmw_check(map_addrs[i], 1, '0);
    end
    report_test("reset_values");

    for (int i = 0; i < RMW_ROUNDS; i++) begin
      sel = {$random(seed)} % 3;
      rmw_check((sel == 0) ? machine_mode_types_pkg::CSR_MSCRATCH :
                (sel == 1) ? machine_mode_types_pkg::CSR_MTOHOST :
                             machine_mode_types_pkg::CSR_MIE,
                {$random(seed)} % 3, $random(seed));
      rmw_check((sel == 0) ? machine_mode_types_pkg::CSR_MSCRATCH :
                (sel == 1) ? machine_mode_types_pkg::CSR_MTOHOST :
                             machine_mode_types_pkg::CSR_MIE, 1, '0);
    end
    // Trap-owned and fixed registers ignore writes
    rmw_check(machine_mode_types_pkg::CSR_MEPC, 0, $random(seed));
    rmw_check(machine_mode_types_pkg::CSR_MEPC, 1, '0);
    rmw_check(machine_mode_types_pkg::CSR_MTVEC, 0, $random(seed));
    rmw_check(machine_mode_types_pkg::CSR_MTVEC, 1, '0);
    rmw_check(machine_mode_types_pkg::CSR_MCAUSE, 0, $random(seed));
    rmw_check(machine_mode_types_pkg::CSR_MCAUSE, 1, '0);
    report_test("read_modify_write");

    // 0x7C0 lies outside the map
    next_drive();
    csr_req.addr  = 12'h7C0;
    csr_req.swap  = 1'b1;
    csr_req.wdata = $random(seed);
    exc.epc       = 32'h0000_2A40;
    #1;
    check_value("invalid_csr", invalid_csr, 1);
    check_value("csr_rdata", csr_rdata, 0);
    check_value("insert_pc", insert_pc, 1);
    check_value("priv_pc", priv_pc, machine_mode_types_pkg::MTVEC_ADDR);
    {m_mepc, m_mcause, m_ie} = {32'h0000_2A40, machine_mode_types_pkg::CAUSE_ILLEGAL, 1'b0};
    rmw_check(machine_mode_types_pkg::CSR_MCAUSE, 1, '0);
    rmw_check(machine_mode_types_pkg::CSR_MEPC, 1, '0);
    report_test("invalid_address");

    for (int i = 0; i < PRIO_ROUNDS; i++) begin
      // Re-enable ie so the trap has a bit to clear
      rmw_check(machine_mode_types_pkg::CSR_MSTATUS, 1, 32'h1);
      event_check(($random(seed) & 4'hF) | ((i % 4 == 0) ? 4'h1 : 4'h0), 1'b0, 1'b0);
      rmw_check(machine_mode_types_pkg::CSR_MCAUSE, 1, '0);
      rmw_check(machine_mode_types_pkg::CSR_MBADADDR, 1, '0);
      rmw_check(machine_mode_types_pkg::CSR_MSTATUS, 1, '0);
    end
    report_test("exception_priority");

    // Interrupt masked by ie, then by meie
    rmw_check(machine_mode_types_pkg::CSR_MIE, 0, 32'h0000_0800);
    rmw_check(machine_mode_types_pkg::CSR_MSTATUS, 0, '0);
    event_check(4'h0, 1'b1, 1'b0);
    rmw_check(machine_mode_types_pkg::CSR_MSTATUS, 0, 32'h1);
    rmw_check(machine_mode_types_pkg::CSR_MIE, 2, 32'h0000_0800);
    event_check(4'h0, 1'b1, 1'b0);
    // Both enables set, then return with MRET
    rmw_check(machine_mode_types_pkg::CSR_MIE, 1, 32'h0000_0800);
    event_check(4'h0, 1'b1, 1'b0);
    rmw_check(machine_mode_types_pkg::CSR_MCAUSE, 1, '0);
    event_check(4'h0, 1'b0, 1'b1);
    rmw_check(machine_mode_types_pkg::CSR_MSTATUS, 1, '0);
    // Exception beats the interrupt and overrides MRET
    event_check(4'h1, 1'b1, 1'b1);
    rmw_check(machine_mode_types_pkg::CSR_MCAUSE, 1, '0);
    event_check(4'h0, 1'b0, 1'b1);
    report_test("interrupt_mret");

    @(posedge CLK);
    #1;
    fail_cnt = fail_cnt + dut_i.sva_i.assert_fail_cnt;
    $display("Checks passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
